//--- ArithUnit.f
+incdir+common
common/arith_pkg.sv
adder/PrefixAndOr.sv
adder/AddSub.sv
design/OperandStage.sv
design/FlagUnit.sv
design/ResultStage.sv
design/ArithUnit.sv
testbench/ArithUnit_asserts.sv
testbench/ArithUnit_tb.sv

//--- adder/AddSub.sv
`timescale 1ns/100ps

module AddSub #(
	parameter int width = 16,  // word width
	parameter int speed = 2    // prefix structure
) (
	input  logic [width-1:0] a,
	input  logic [width-1:0] b,
	input  logic             sub,      // a - b when set
	output logic [width-1:0] sum,
	output logic             carryOut  // from top group generate
);

	logic [width-1:0] bEff;     // b, inverted on subtract
	logic [width-1:0] gIn;      // prefix generate in
	logic [width-1:0] pIn;      // prefix propagate in
	logic [width-1:0] gOut;     // carry out of each bit
	logic [width-1:0] halfSum;  // a xor bEff

	assign bEff = b ^ {width{sub}};

	// carry in folded into bit 0, so bit 0 never propagates
	assign gIn[0] = (a[0] & bEff[0]) | (sub & (a[0] | bEff[0]));
	assign pIn[0] = 1'b0;

	for (genvar i = 1; i < width; i++) begin : preBits
		assign gIn[i] = a[i] & bEff[i];
		assign pIn[i] = a[i] | bEff[i];
	end

	assign halfSum = a ^ bEff;

	PrefixAndOr #(
		.width(width),
		.speed(speed)
	) prefix_i (
		.gIn (gIn),
		.pIn (pIn),
		.gOut(gOut),
		.pOut()  // group propagate not needed for a plain sum
	);

	assign sum      = halfSum ^ {gOut[width-2:0], sub};  // carries shifted up one bit
	assign carryOut = gOut[width-1];

endmodule

//--- adder/PrefixAndOr.sv
`timescale 1ns/100ps

module PrefixAndOr #(
	parameter int width = 16,  // word width
	parameter int speed = 2    // 0 serial, 1 brent-kung, 2 sklansky
) (
	input  logic [width-1:0] gIn,   // per-bit generate
	input  logic [width-1:0] pIn,   // per-bit propagate
	output logic [width-1:0] gOut,  // group generate over bits i..0
	output logic [width-1:0] pOut   // group propagate over bits i..0
);

	localparam int depth = (width > 1) ? $clog2(width) : 1;  // tree levels

	if (speed == 0) begin : serialPrefix
		logic [width-1:0] gChain;  // ripple chain
		logic [width-1:0] pChain;

		assign gChain[0] = gIn[0];
		assign pChain[0] = pIn[0];
		for (genvar i = 1; i < width; i++) begin : bits
			assign gChain[i] = gIn[i] | (pIn[i] & gChain[i-1]);
			assign pChain[i] = pIn[i] & pChain[i-1];
		end
		assign gOut = gChain;
		assign pOut = pChain;
	end else if (speed == 1) begin : brentKungPrefix
		localparam int stages = 2 * depth - 1;  // up plus down sweep
		logic [width-1:0] gT [0:stages];
		logic [width-1:0] pT [0:stages];

		assign gT[0] = gIn;
		assign pT[0] = pIn;

		// up-sweep, one node at the top of every 2^l block
		for (genvar l = 1; l <= depth; l++) begin : upLevels
			for (genvar i = 0; i < width; i++) begin : bits
				if ((i + 1) % (2 ** l) == 0) begin : black
					assign gT[l][i] = gT[l-1][i]
						| (pT[l-1][i] & gT[l-1][i - 2**(l-1)]);
					assign pT[l][i] = pT[l-1][i] & pT[l-1][i - 2**(l-1)];
				end else begin : white
					assign gT[l][i] = gT[l-1][i];  // pass through
					assign pT[l][i] = pT[l-1][i];
				end
			end
		end

		// down-sweep fills in the block midpoints
		for (genvar t = 1; t < depth; t++) begin : downLevels
			localparam int span = 2 ** (depth - t);
			for (genvar i = 0; i < width; i++) begin : bits
				if (i >= span && (i + 1) % span == span / 2) begin : black
					assign gT[depth+t][i] = gT[depth+t-1][i]
						| (pT[depth+t-1][i] & gT[depth+t-1][i - span/2]);
					assign pT[depth+t][i] = pT[depth+t-1][i]
						& pT[depth+t-1][i - span/2];
				end else begin : white
					assign gT[depth+t][i] = gT[depth+t-1][i];
					assign pT[depth+t][i] = pT[depth+t-1][i];
				end
			end
		end

		assign gOut = gT[stages];
		assign pOut = pT[stages];
	end else begin : sklanskyPrefix
		logic [width-1:0] gT [0:depth];
		logic [width-1:0] pT [0:depth];

		assign gT[0] = gIn;
		assign pT[0] = pIn;

		// level l: upper half of each 2^l block takes the lower half's top bit
		for (genvar l = 1; l <= depth; l++) begin : levels
			for (genvar i = 0; i < width; i++) begin : bits
				if ((i / (2 ** (l-1))) % 2 == 1) begin : black
					localparam int src = (i / (2 ** (l-1))) * (2 ** (l-1)) - 1;  // fan-out bit
					assign gT[l][i] = gT[l-1][i] | (pT[l-1][i] & gT[l-1][src]);
					assign pT[l][i] = pT[l-1][i] & pT[l-1][src];
				end else begin : white
					assign gT[l][i] = gT[l-1][i];
					assign pT[l][i] = pT[l-1][i];
				end
			end
		end

		assign gOut = gT[depth];
		assign pOut = pT[depth];
	end

endmodule

//--- common/arith_pkg.sv
package arith_pkg;

`include "arith_settings.svh"

	typedef enum logic [2:0] {
		opAdd    = 3'd0,  // a + b
		opSub    = 3'd1,  // a - b
		opAccAdd = 3'd2,  // acc + a
		opAccSub = 3'd3,  // acc - a
		opLoad   = 3'd4   // a + 0, lands in acc
	} opCodeT;

	typedef struct packed {
		opCodeT                 op;
		logic [`ARITH_WIDTH-1:0] a;
		logic [`ARITH_WIDTH-1:0] b;
	} requestT;

	typedef struct packed {
		logic carry;     // carry out, set on subtract means no borrow
		logic overflow;  // signed overflow
		logic zero;
		logic negative;
	} flagsT;

	typedef struct packed {
		logic [`ARITH_WIDTH-1:0] value;
		flagsT                  flags;
	} resultT;

	// ops whose sum is written back into the accumulator
	function automatic logic writesAcc(opCodeT op);
		return op inside {opAccAdd, opAccSub, opLoad};
	endfunction

	function automatic logic isSub(opCodeT op);
		return op inside {opSub, opAccSub};
	endfunction

endpackage

//--- common/arith_settings.svh
`ifndef ARITH_SETTINGS_SVH
`define ARITH_SETTINGS_SVH

// data word width of operands, results and accumulator
`define ARITH_WIDTH 16

// prefix network choice
// 0 serial ripple, 1 brent-kung, 2 sklansky
`define ARITH_SPEED 2

`endif

//--- design/ArithUnit.sv
`timescale 1ns/100ps
`include "arith_settings.svh"

module ArithUnit (
	input  logic               clk,
	input  logic               reset,
	input  logic               inStrobe,
	input  arith_pkg::requestT request,
	output logic               outValid,
	output arith_pkg::resultT  result
);

	logic [`ARITH_WIDTH-1:0] opA;
	logic [`ARITH_WIDTH-1:0] opB;
	logic                    sub;
	arith_pkg::opCodeT       stagedOp;
	logic                    stagedValid;
	logic [`ARITH_WIDTH-1:0] sum;
	logic                    carryOut;
	arith_pkg::flagsT        flags;
	logic [`ARITH_WIDTH-1:0] acc;       // accumulator feedback

	// stage 1, request register and operand mux
	OperandStage operand_i (
		.clk        (clk),
		.reset      (reset),
		.inStrobe   (inStrobe),
		.request    (request),
		.acc        (acc),
		.opA        (opA),
		.opB        (opB),
		.sub        (sub),
		.stagedOp   (stagedOp),
		.stagedValid(stagedValid)
	);

	AddSub #(
		.width(`ARITH_WIDTH),
		.speed(`ARITH_SPEED)
	) addSub_i (
		.a       (opA),
		.b       (opB),
		.sub     (sub),
		.sum     (sum),
		.carryOut(carryOut)
	);

	FlagUnit flag_i (
		.opA     (opA),
		.opB     (opB),
		.sub     (sub),
		.sum     (sum),
		.carryOut(carryOut),
		.flags   (flags)
	);

	// stage 2, result register and accumulator
	ResultStage resultStage_i (
		.clk        (clk),
		.reset      (reset),
		.stagedValid(stagedValid),
		.stagedOp   (stagedOp),
		.sum        (sum),
		.flags      (flags),
		.outValid   (outValid),
		.result     (result),
		.acc        (acc)
	);

endmodule

//--- design/FlagUnit.sv
`timescale 1ns/100ps
`include "arith_settings.svh"

module FlagUnit (
	input  logic [`ARITH_WIDTH-1:0] opA,
	input  logic [`ARITH_WIDTH-1:0] opB,
	input  logic                    sub,
	input  logic [`ARITH_WIDTH-1:0] sum,
	input  logic                    carryOut,
	output arith_pkg::flagsT        flags
);

	localparam int msb = `ARITH_WIDTH - 1;

	logic [`ARITH_WIDTH-1:0] addend;  // what the adder really added

	assign addend = opB ^ {`ARITH_WIDTH{sub}};

	always_comb begin
		flags.carry    = carryOut;  // no borrow on subtract
		// same-sign inputs, result sign flipped
		flags.overflow = (opA[msb] == addend[msb]) && (sum[msb] != opA[msb]);
		flags.zero     = (sum == '0);
		flags.negative = sum[msb];
	end

endmodule

//--- design/OperandStage.sv
`timescale 1ns/100ps
`include "arith_settings.svh"

module OperandStage (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    inStrobe,
	input  arith_pkg::requestT      request,
	input  logic [`ARITH_WIDTH-1:0] acc,          // from result stage
	output logic [`ARITH_WIDTH-1:0] opA,
	output logic [`ARITH_WIDTH-1:0] opB,
	output logic                    sub,
	output arith_pkg::opCodeT       stagedOp,
	output logic                    stagedValid
);

	arith_pkg::requestT staged;  // held request

	always_ff @(posedge clk) begin
		if (reset) begin
			stagedValid <= 1'b0;
		end else begin
			stagedValid <= inStrobe;  // drops on idle cycles
		end
	end

	always_ff @(posedge clk) begin
		if (inStrobe) begin
			staged <= request;
		end
	end

	assign stagedOp = staged.op;
	assign sub      = arith_pkg::isSub(staged.op);

	// operand routing per op
	always_comb begin
		case (staged.op)
			arith_pkg::opAccAdd, arith_pkg::opAccSub: begin
				opA = acc;       // accumulator on the left
				opB = staged.a;
			end
			arith_pkg::opLoad: begin
				opA = staged.a;
				opB = '0;        // pass a straight through
			end
			default: begin
				opA = staged.a;
				opB = staged.b;
			end
		endcase
	end

endmodule

//--- design/ResultStage.sv
`timescale 1ns/100ps
`include "arith_settings.svh"

module ResultStage (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    stagedValid,
	input  arith_pkg::opCodeT       stagedOp,
	input  logic [`ARITH_WIDTH-1:0] sum,
	input  arith_pkg::flagsT        flags,
	output logic                    outValid,
	output arith_pkg::resultT       result,
	output logic [`ARITH_WIDTH-1:0] acc       // back to operand stage
);

	logic accWrite;  // staged op updates acc this edge

	assign accWrite = stagedValid && arith_pkg::writesAcc(stagedOp);

	// valid and accumulator
	always_ff @(posedge clk) begin
		if (reset) begin
			outValid <= 1'b0;
			acc      <= '0;
		end else begin
			outValid <= stagedValid;
			if (accWrite) begin
				acc <= sum;  // same edge that stages the next request
			end
		end
	end

	// result payload, only touched for real entries
	always_ff @(posedge clk) begin
		if (stagedValid) begin
			result.value <= sum;
			result.flags <= flags;
		end
	end

endmodule

//--- testbench/ArithUnit_asserts.sv
`timescale 1ns/100ps

module ArithUnit_asserts (
	input logic clk,
	input logic reset,
	input logic inStrobe,
	input logic outValid
);

	int failCount = 0;  // polled by the testbench

	// quiet under reset and one cycle beyond
	resetQuiet: assert property (@(posedge clk) reset |=> !outValid ##1 !outValid)
		else begin
			failCount++;
			$error("outValid high during reset or the cycle after");
		end

	// two-edge latency once reset is two edges gone
	latencyTwo: assert property (@(posedge clk)
		(!$past(reset, 1) && !$past(reset, 2)) |-> outValid == $past(inStrobe, 2))
		else begin
			failCount++;
			$error("outValid not equal to inStrobe two edges earlier");
		end

	dropResetStrobe: assert property (@(posedge clk) (reset && inStrobe) |-> ##2 !outValid)
		else begin
			failCount++;
			$error("strobe taken under reset produced outValid");
		end

endmodule

bind ArithUnit ArithUnit_asserts timingChecks_i (
	.clk     (clk),
	.reset   (reset),
	.inStrobe(inStrobe),
	.outValid(outValid)
);

//--- testbench/ArithUnit_tb.sv
`timescale 1ns/100ps
`include "arith_settings.svh"

module ArithUnit_tb;

	localparam int traceMax = 64;  // lines the trace memory holds
	localparam int cols     = 6;   // strobe op a b value flags

	logic               clk;
	logic               reset;
	logic               inStrobe;
	arith_pkg::requestT request;
	logic               outValid;
	arith_pkg::resultT  result;

	logic [`ARITH_WIDTH-1:0] traceMem [0:traceMax*cols-1];
	arith_pkg::resultT       expected [$];  // in request order
	int traceLines = 0;
	int strobes    = 0;
	int seen       = 0;
	int cycles     = 0;
	int cycleLimit = 1000;  // replaced once the trace is read

	ArithUnit ArithUnit_i (
		.clk     (clk),
		.reset   (reset),
		.inStrobe(inStrobe),
		.request (request),
		.outValid(outValid),
		.result  (result)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;  // 4 ns period
	end

	task automatic failRun(string why);
		$display("%s", why);
		$display("STATUS: FAIL");
		$fatal(1);
	endtask

	task automatic checkValue(string name, logic [31:0] got, logic [31:0] want);
		if (got !== want) begin
			failRun($sformatf("FAILED %s got %h expected %h", name, got, want));
		end
	endtask

	always @(posedge clk) begin
		cycles++;
		if (cycles >= cycleLimit) begin
			failRun($sformatf("timeout after %0d cycles with %0d of %0d results seen",
				cycles, seen, strobes));
		end
	end

	// outputs settle well before the falling edge
	always @(negedge clk) begin
		arith_pkg::resultT want;
		if (ArithUnit_i.timingChecks_i.failCount != 0) begin
			failRun("a timing assertion on outValid failed");
		end else if (outValid === 1'b1 && expected.size() == 0) begin
			failRun("outValid pulsed with no request pending");
		end else if (outValid === 1'b1) begin
			want = expected.pop_front();
			checkValue("result.value", result.value, want.value);
			checkValue("result.flags", result.flags, want.flags);
			seen++;
		end
	end

	initial begin
		arith_pkg::resultT entry;
		int i;
		reset    = 1'b1;
		inStrobe = 1'b0;
		request  = '0;
		$readmemh("testbench/arith_trace.txt", traceMem);
		while (traceLines < traceMax && !$isunknown(traceMem[traceLines*cols])) begin
			strobes += traceMem[traceLines*cols][0];
			traceLines++;
		end
		cycleLimit = traceLines + 8 + 20;  // reset, trace, margin
		repeat (7) @(posedge clk);
		#1;
		inStrobe   = 1'b1;  // sampled on the last reset edge, must never come out
		request.op = arith_pkg::opAdd;
		request.a  = 'h1111;
		request.b  = 'h2222;
		@(posedge clk);
		#1;
		inStrobe = 1'b0;
		reset    = 1'b0;  // 8 edges under reset
		for (i = 0; i < traceLines; i++) begin
			@(posedge clk);
			#1;
			inStrobe   = traceMem[i*cols][0];
			request.op = arith_pkg::opCodeT'(traceMem[i*cols+1][2:0]);
			request.a  = traceMem[i*cols+2];
			request.b  = traceMem[i*cols+3];
			if (inStrobe) begin
				entry.value = traceMem[i*cols+4];
				entry.flags = arith_pkg::flagsT'(traceMem[i*cols+5][3:0]);
				expected.push_back(entry);
			end
		end
		@(posedge clk);
		#1 inStrobe = 1'b0;
		wait (seen == strobes);
		repeat (3) @(posedge clk);  // room for a stray outValid
		if (seen == strobes && ArithUnit_i.timingChecks_i.failCount == 0) begin
			$display("STATUS: PASS");
			$finish;
		end else begin
			failRun("result count or timing checks wrong at end of run");
		end
	end

endmodule

//--- testbench/arith_trace.txt
// strobe op a b value flags, one request per line, all hex
// op 0 add 1 sub 2 accAdd 3 accSub 4 load, flags nibble is carry overflow zero negative
1 0 0003 0004 0007 0 // plain add
1 0 FFFF 0001 0000 A // all ones plus one
1 1 0009 0004 0005 8 // no borrow
1 1 0004 0009 FFFB 1 // borrow
0 0 0000 0000 0000 0
1 0 7FFF 0001 8000 5 // pos plus pos overflow
1 1 8000 0001 7FFF C // neg minus pos overflow
1 0 FFFE 0005 0003 8 // mixed sign, no overflow
1 1 1234 1234 0000 A // a minus a
0 0 0000 0000 0000 0
1 4 0010 0000 0010 0 // load acc
1 2 0005 0000 0015 0
1 3 0020 0000 FFF5 1
1 0 0100 0200 0300 0 // acc untouched
1 1 0001 0002 FFFF 1
1 2 000B 0000 0000 A // acc was still FFF5
0 0 0000 0000 0000 0
0 0 0000 0000 0000 0
1 3 0001 0000 FFFF 1
0 0 0000 0000 0000 0
1 4 8000 0000 8000 1
1 3 0001 0000 7FFF C
1 2 0001 0000 8000 5
1 0 7FFF 8000 FFFF 1
